//--- Bender.yml
package:
  name: cache_way

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/cacheWayPkg.sv
      - hdl/ramSinglePortBe.sv
      - hdl/lineStateBits.sv
      - hdl/cacheWay.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/cacheWayTb.sv

//--- cacheWay.f
+incdir+include
hdl/cacheWayPkg.sv
hdl/ramSinglePortBe.sv
hdl/lineStateBits.sv
hdl/cacheWay.sv
test/cacheWayTb.sv

//--- hdl/cacheWay.sv
////////////////////////////////////////////////////////////
// One way of a set-associative data cache
// Results appear one edge after the access and hold until
// the next ce; no way selection or refill traffic here
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cacheWay import cacheWayPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       ce,
  input  setIdxT     setIdx,
  input  tagT        lookupTag,
  input  lineByteEnT byteEn,
  input  lineT       writeData,
  input  logic       dataWe,
  input  logic       fill,
  input  logic       invalidate,
  output logic       hit,
  output logic       dirty,
  output lineT       readData,
  output tagT        victimTag
);

  // Stored tag of the sampled set
  tagT storedTag;

  // Lookup tag aligned with the array outputs
  tagT lookupTagQ;

  // Valid bit of the sampled set
  logic setValid;

  // Data array enables and write strobe
  lineByteEnT dataBwe;
  logic       dataWrite;

  ////////////////////////////////////////////////////////////
  // Tag array
  ////////////////////////////////////////////////////////////

  // Tag written only by a fill, always as a whole word
  ramSinglePortBe #(
    .wordT(tagT)
  ) tagArray (
    .clk (clk),
    .ce  (ce),
    .addr(setIdx),
    .din (lookupTag),
    .we  (fill),
    .bwe ('1),
    .dout(storedTag)
  );

  ////////////////////////////////////////////////////////////
  // Data array
  ////////////////////////////////////////////////////////////

  // Fill replaces the whole line, store merges chosen bytes
  assign dataBwe   = fill ? '1 : byteEn;
  assign dataWrite = dataWe | fill;

  ramSinglePortBe #(
    .wordT(lineT)
  ) dataArray (
    .clk (clk),
    .ce  (ce),
    .addr(setIdx),
    .din (writeData),
    .we  (dataWrite),
    .bwe (dataBwe),
    .dout(readData)
  );

  ////////////////////////////////////////////////////////////
  // State bits and hit
  ////////////////////////////////////////////////////////////

  lineStateBits stateBits (
    .clk       (clk),
    .rstN      (rstN),
    .ce        (ce),
    .setIdx    (setIdx),
    .fill      (fill),
    .dataWe    (dataWe),
    .invalidate(invalidate),
    .valid     (setValid),
    .dirty     (dirty)
  );

  // Loads with the array address registers
  always_ff @(posedge clk) begin
    if (ce) begin
      lookupTagQ <= lookupTag;
    end
  end

  assign hit       = setValid && (storedTag == lookupTagQ);
  assign victimTag = storedTag;

  // Operations are exclusive within one access
  oneOperation: assert property (@(posedge clk) disable iff (!rstN)
    ce |-> $onehot0({dataWe, fill, invalidate}))
    else $error("cacheWay: more than one operation in one access");

endmodule

//--- hdl/cacheWayPkg.sv
////////////////////////////////////////////////////////////
// Shared types of the cache way
// Widths follow the macros in cacheWay_consts.svh
////////////////////////////////////////////////////////////

`include "cacheWay_consts.svh"

package cacheWayPkg;

  // Set index, wide enough for every set
  typedef logic [$clog2(`CACHE_SETS)-1:0] setIdxT;

  // Address tag held per set
  typedef logic [`CACHE_TAG_BITS-1:0] tagT;

  // One full data line
  typedef logic [`CACHE_LINE_BYTES*8-1:0] lineT;

  // One enable per byte of a line
  typedef logic [`CACHE_LINE_BYTES-1:0] lineByteEnT;

endpackage

//--- hdl/lineStateBits.sv
////////////////////////////////////////////////////////////
// Valid and dirty bits for every set of one way
// Outputs show the set sampled at the last ce edge,
// including the update made at that edge
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lineStateBits import cacheWayPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   ce,
  input  setIdxT setIdx,
  input  logic   fill,
  input  logic   dataWe,
  input  logic   invalidate,
  output logic   valid,
  output logic   dirty
);

  // One entry per reachable set index
  localparam int numSets = 2 ** $bits(setIdxT);

  logic [numSets-1:0] validBits;
  logic [numSets-1:0] dirtyBits;

  // Set sampled on the last access
  setIdxT idxQ;

  // State update and index register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validBits <= '0;
      dirtyBits <= '0;
      idxQ      <= '0;
    end else if (ce) begin
      idxQ <= setIdx;
      if (fill) begin
        // Fresh line from memory, clean
        validBits[setIdx] <= 1'b1;
        dirtyBits[setIdx] <= 1'b0;
      end else if (dataWe) begin
        dirtyBits[setIdx] <= 1'b1;
      end else if (invalidate) begin
        validBits[setIdx] <= 1'b0;
        dirtyBits[setIdx] <= 1'b0;
      end
    end
  end

  // Bits of the sampled set
  assign valid = validBits[idxQ];
  assign dirty = dirtyBits[idxQ];

  // The cache only stores after a hit, so the target must be valid
  storeOnValid: assert property (@(posedge clk) disable iff (!rstN)
    (ce && dataWe) |-> validBits[setIdx])
    else $error("lineStateBits: store to an invalid set");

endmodule

//--- hdl/ramSinglePortBe.sv
////////////////////////////////////////////////////////////
// Single-port SRAM model with byte write enables
// Read data follows the address sampled at the last ce edge
// and already shows the write of that same edge
// Contents are not reset and start undefined
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cacheWay_consts.svh"

module ramSinglePortBe import cacheWayPkg::*; #(
  parameter type wordT = lineT,
  parameter int  depth = `CACHE_SETS
) (
  input  logic                          clk,
  input  logic                          ce,
  input  setIdxT                        addr,
  input  wordT                          din,
  input  logic                          we,
  input  logic [($bits(wordT)-1)/8:0]   bwe,
  output wordT                          dout
);

  // Payload width in bits
  localparam int width = $bits(wordT);

  // Storage array
  wordT mem [depth];

  // Address sampled on the last access
  setIdxT addrQ;

  // Per-bit write mask expanded from the byte enables
  logic [width-1:0] bitMask;

  ////////////////////////////////////////////////////////////
  // Write mask
  ////////////////////////////////////////////////////////////

  // Bit b belongs to lane b/8
  // Top bits of a partial lane land on the last enable
  for (genvar b = 0; b < width; b++) begin : genBitMask
    assign bitMask[b] = bwe[b/8];
  end

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Merge enabled lanes into the stored word
  always_ff @(posedge clk) begin
    if (ce && we) begin
      mem[addr] <= (mem[addr] & ~bitMask) | (din & bitMask);
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Address register loads only with an access, so dout holds
  always_ff @(posedge clk) begin
    if (ce) begin
      addrQ <= addr;
    end
  end

  // Array read after the edge, sees this edge's write
  assign dout = mem[addrQ];

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // An access needs a known address, or a random word is hit
  addrKnown: assert property (@(posedge clk) ce |-> !$isunknown(addr))
    else $error("ramSinglePortBe: unknown address on access");

endmodule

//--- include/cacheWay_consts.svh
////////////////////////////////////////////////////////////
// Geometry of one cache way, shared by RTL and testbench
// Tag width is not a multiple of 8, so the tag array
// carries a partial top byte lane
////////////////////////////////////////////////////////////

`ifndef CACHE_WAY_CONSTS_SVH
`define CACHE_WAY_CONSTS_SVH

// Number of sets in the way
`define CACHE_SETS 64

// Bytes per cache line
`define CACHE_LINE_BYTES 16

// Stored address tag width
`define CACHE_TAG_BITS 20

`endif

//--- test/cacheWayTb.sv
////////////////////////////////////////////////////////////
// Testbench for one cache way, driven by a stimulus file
// Each access is checked mid cycle after its idle gap
// Reads test/cacheWay_stimulus.txt from the project root
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cacheWay_consts.svh"

module cacheWayTb import cacheWayPkg::*; ();

  // Bounds for the file open retries and the read loop
  localparam int openTries    = 4;
  localparam int maxFileLines = 200;

  logic       clk;
  logic       rstN;
  logic       ce;
  setIdxT     setIdx;
  tagT        lookupTag;
  lineByteEnT byteEn;
  lineT       writeData;
  logic       dataWe;
  logic       fill;
  logic       invalidate;
  logic       hit;
  logic       dirty;
  lineT       readData;
  tagT        victimTag;

  cacheWay dut0 (
    .clk       (clk),
    .rstN      (rstN),
    .ce        (ce),
    .setIdx    (setIdx),
    .lookupTag (lookupTag),
    .byteEn    (byteEn),
    .writeData (writeData),
    .dataWe    (dataWe),
    .fill      (fill),
    .invalidate(invalidate),
    .hit       (hit),
    .dirty     (dirty),
    .readData  (readData),
    .victimTag (victimTag)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stopOnFailure();
    $display("Checks failed");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic checkBit(input string testName, input string what,
                          input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("error %s: %s expected %b actual %b", testName, what, expVal, actVal);
      stopOnFailure();
    end
  endtask

  task automatic checkLine(input string testName, input lineT expVal, input lineT actVal);
    if (actVal !== expVal) begin
      $display("error %s: readData expected %h actual %h", testName, expVal, actVal);
      stopOnFailure();
    end
  endtask

  task automatic checkTag(input string testName, input tagT expVal, input tagT actVal);
    if (actVal !== expVal) begin
      $display("error %s: victimTag expected %h actual %h", testName, expVal, actVal);
      stopOnFailure();
    end
  endtask

  // Skips comment lines starting with '#' and blank lines
  function automatic bit isDataLine(input string s);
    byte c;
    if (s.len() == 0) begin
      return 1'b0;
    end
    c = s.getc(0);
    return !(c == "#" || c == "\n" || c == "\r");
  endfunction

  // Drives one access with ce high for exactly one sampling edge
  task automatic applyAccess(input string opStr, input setIdxT setVal, input tagT tagVal,
                             input lineByteEnT beVal, input lineT dataVal);
    @(posedge clk);
    ce         <= 1'b1;
    setIdx     <= setVal;
    lookupTag  <= tagVal;
    byteEn     <= beVal;
    writeData  <= dataVal;
    dataWe     <= (opStr == "S");
    fill       <= (opStr == "F");
    invalidate <= (opStr == "I");
    // Outputs show this access from the sampling edge on
    @(posedge clk);
    ce         <= 1'b0;
    dataWe     <= 1'b0;
    fill       <= 1'b0;
    invalidate <= 1'b0;
    // Idle address and tag differ so that an output which fails to hold shows up
    setIdx     <= ~setVal;
    lookupTag  <= ~tagVal;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          tries;
    int          lineCount;
    int          numAccesses;
    int          fields;
    int          setNum;
    string       lineStr;
    string       testName;
    string       opStr;
    string       rdStr;
    string       vtStr;
    tagT         tagVal;
    lineByteEnT  beVal;
    lineT        dataVal;
    logic        expHit;
    logic        expDirty;
    lineT        expLine;
    tagT         expTag;

    void'($urandom(32'h10ce5469));

    rstN       <= 1'b0;
    ce         <= 1'b0;
    setIdx     <= '0;
    lookupTag  <= '0;
    byteEn     <= '0;
    writeData  <= '0;
    dataWe     <= 1'b0;
    fill       <= 1'b0;
    invalidate <= 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;

    // Open with a bounded number of retries
    fd    = 0;
    tries = 0;
    while (fd == 0 && tries < openTries) begin
      fd = $fopen("test/cacheWay_stimulus.txt", "r");
      tries++;
      if (fd == 0) begin
        @(posedge clk);
      end
    end
    if (fd == 0) begin
      $display("could not open the stimulus file test/cacheWay_stimulus.txt");
      stopOnFailure();
    end

    lineCount   = 0;
    numAccesses = 0;
    while (!$feof(fd)) begin
      lineCount++;
      if (lineCount > maxFileLines) begin
        $display("stimulus file did not end within %0d lines", maxFileLines);
        stopOnFailure();
      end
      lineStr = "";
      void'($fgets(lineStr, fd));
      if (!isDataLine(lineStr)) begin
        continue;
      end
      fields = $sscanf(lineStr, "%s %s %h %h %h %h %b %b %s %s",
                       testName, opStr, setNum, tagVal, beVal, dataVal,
                       expHit, expDirty, rdStr, vtStr);
      if (fields != 10) begin
        $display("stimulus line %0d does not hold ten fields", lineCount);
        stopOnFailure();
      end
      if (setNum < 0 || setNum >= `CACHE_SETS) begin
        $display("stimulus line %0d names a set outside the way", lineCount);
        stopOnFailure();
      end
      if (!(opStr == "L" || opStr == "S" || opStr == "F" || opStr == "I")) begin
        $display("stimulus line %0d has an unknown operation letter", lineCount);
        stopOnFailure();
      end

      applyAccess(opStr, setIdxT'(setNum), tagVal, beVal, dataVal);
      // Outputs must hold through idle cycles with ce low
      repeat ($urandom_range(3, 0)) @(posedge clk);
      // Mid cycle where the outputs are settled
      @(negedge clk);

      checkBit(testName, "hit", expHit, hit);
      checkBit(testName, "dirty", expDirty, dirty);
      if (rdStr != "-") begin
        void'($sscanf(rdStr, "%h", expLine));
        checkLine(testName, expLine, readData);
      end
      if (vtStr != "-") begin
        void'($sscanf(vtStr, "%h", expTag));
        checkTag(testName, expTag, victimTag);
      end
      numAccesses++;
    end
    $fclose(fd);

    if (numAccesses == 0) begin
      $display("stimulus file held no accesses");
      stopOnFailure();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- test/cacheWay_stimulus.txt
# name op set tag byteEn writeData expHit expDirty expReadData expVictimTag
# op L lookup, S store, F fill, I invalidate; '-' skips the readData or victimTag check
# Every set is invalid after reset
rstLook00 L 00 00000 0000 00000000000000000000000000000000 0 0 - -
rstLook05 L 05 abcde 0000 00000000000000000000000000000000 0 0 - -
rstLook3f L 3f fffff 0000 00000000000000000000000000000000 0 0 - -
# Fill shows its own result, then a lookup with the same tag hits
fill05 F 05 abcde 0000 00112233445566778899aabbccddeeff 1 0 00112233445566778899aabbccddeeff abcde
look05 L 05 abcde 0000 00000000000000000000000000000000 1 0 00112233445566778899aabbccddeeff abcde
# Another tag in a filled set misses
miss05 L 05 12345 0000 00000000000000000000000000000000 0 0 00112233445566778899aabbccddeeff abcde
# Byte-masked stores merge only the enabled bytes
store05Lo S 05 abcde 000f 11111111222222223333333344444444 1 1 00112233445566778899aabb44444444 abcde
store05Ends S 05 abcde 8001 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 1 a5112233445566778899aabb444444a5 abcde
look05Dirty L 05 abcde 0000 00000000000000000000000000000000 1 1 a5112233445566778899aabb444444a5 abcde
# Invalidate clears one set, the neighbor keeps hitting
fill06 F 06 0f00f 0000 fedcba9876543210fedcba9876543210 1 0 fedcba9876543210fedcba9876543210 0f00f
inval05 I 05 abcde 0000 00000000000000000000000000000000 0 0 a5112233445566778899aabb444444a5 abcde
look05Gone L 05 abcde 0000 00000000000000000000000000000000 0 0 a5112233445566778899aabb444444a5 abcde
look06Kept L 06 0f00f 0000 00000000000000000000000000000000 1 0 fedcba9876543210fedcba9876543210 0f00f
# Dirty set refilled with a new tag, top tag nibble changes
fill07 F 07 13579 0000 0123456789abcdef0123456789abcdef 1 0 0123456789abcdef0123456789abcdef 13579
store07Hi S 07 13579 ff00 00000000000000000000000000000000 1 1 00000000000000000123456789abcdef 13579
miss07 L 07 2468a 0000 00000000000000000000000000000000 0 1 00000000000000000123456789abcdef 13579
refill07 F 07 f2468 0000 cafef00dcafef00dcafef00dcafef00d 1 0 cafef00dcafef00dcafef00dcafef00d f2468
look07New L 07 f2468 0000 00000000000000000000000000000000 1 0 cafef00dcafef00dcafef00dcafef00d f2468
look07Old L 07 13579 0000 00000000000000000000000000000000 0 0 cafef00dcafef00dcafef00dcafef00d f2468
# Top set and set 0 stay apart
fill3f F 3f fffff 0000 ffffffffffffffffffffffffffffffff 1 0 ffffffffffffffffffffffffffffffff fffff
look00Miss L 00 fffff 0000 00000000000000000000000000000000 0 0 - -
look3f L 3f fffff 0000 00000000000000000000000000000000 1 0 ffffffffffffffffffffffffffffffff fffff
store3fMid S 3f fffff 0ff0 00000000000000000000000000000000 1 1 ffffffff0000000000000000ffffffff fffff
inval3f I 3f 00000 0000 00000000000000000000000000000000 0 0 ffffffff0000000000000000ffffffff fffff
look3fGone L 3f fffff 0000 00000000000000000000000000000000 0 0 ffffffff0000000000000000ffffffff fffff
# Earlier sets are untouched by later accesses
look06Again L 06 0f00f 0000 00000000000000000000000000000000 1 0 fedcba9876543210fedcba9876543210 0f00f
look07Again L 07 f2468 0000 00000000000000000000000000000000 1 0 cafef00dcafef00dcafef00dcafef00d f2468
look05Still L 05 abcde 0000 00000000000000000000000000000000 0 0 a5112233445566778899aabb444444a5 abcde
